// ==== hw/mips_pkg.sv ====
package mips_pkg;

	// major opcodes
	localparam logic [5:0]
		op_r_type = 6'b000000, op_regimm = 6'b000001, op_j = 6'b000010, op_jal = 6'b000011,
		op_beq = 6'b000100, op_bne = 6'b000101, op_blez = 6'b000110, op_bgtz = 6'b000111,
		op_addi = 6'b001000, op_addiu = 6'b001001, op_slti = 6'b001010, op_sltiu = 6'b001011,
		op_andi = 6'b001100, op_ori = 6'b001101, op_xori = 6'b001110, op_lui = 6'b001111,
		op_cop0 = 6'b010000, op_beql = 6'b010100, op_bnel = 6'b010101, op_blezl = 6'b010110,
		op_bgtzl = 6'b010111, op_special2 = 6'b011100,
		op_lb = 6'b100000, op_lh = 6'b100001, op_lwl = 6'b100010, op_lw = 6'b100011,
		op_lbu = 6'b100100, op_lhu = 6'b100101, op_lwr = 6'b100110,
		op_sb = 6'b101000, op_sh = 6'b101001, op_swl = 6'b101010, op_sw = 6'b101011,
		op_swr = 6'b101110, op_cache = 6'b101111,
		op_ll = 6'b110000, op_pref = 6'b110011, op_sc = 6'b111000;

	// SPECIAL funct field
	localparam logic [5:0]
		fn_sll = 6'b000000, fn_srl = 6'b000010, fn_sra = 6'b000011, fn_sllv = 6'b000100,
		fn_srlv = 6'b000110, fn_srav = 6'b000111, fn_jr = 6'b001000, fn_jalr = 6'b001001,
		fn_movz = 6'b001010, fn_movn = 6'b001011, fn_syscall = 6'b001100, fn_break = 6'b001101,
		fn_sync = 6'b001111, fn_mfhi = 6'b010000, fn_mthi = 6'b010001, fn_mflo = 6'b010010,
		fn_mtlo = 6'b010011, fn_mult = 6'b011000, fn_multu = 6'b011001, fn_div = 6'b011010,
		fn_divu = 6'b011011, fn_add = 6'b100000, fn_addu = 6'b100001, fn_sub = 6'b100010,
		fn_subu = 6'b100011, fn_and = 6'b100100, fn_or = 6'b100101, fn_xor = 6'b100110,
		fn_nor = 6'b100111, fn_slt = 6'b101010, fn_sltu = 6'b101011,
		fn_tge = 6'b110000, fn_tgeu = 6'b110001, fn_tlt = 6'b110010, fn_tltu = 6'b110011,
		fn_teq = 6'b110100, fn_tne = 6'b110110;

	// SPECIAL2 funct field
	localparam logic [5:0]
		s2_madd = 6'b000000, s2_maddu = 6'b000001, s2_mul = 6'b000010, s2_msub = 6'b000100,
		s2_msubu = 6'b000101, s2_clz = 6'b100000, s2_clo = 6'b100001;

	// COP0 funct field when the CO bit is set
	localparam logic [5:0]
		c0_tlbr = 6'b000001, c0_tlbwi = 6'b000010, c0_tlbwr = 6'b000110, c0_tlbp = 6'b001000,
		c0_eret = 6'b011000, c0_wait = 6'b100000;

	// REGIMM rt field
	localparam logic [4:0]
		rt_bltz = 5'b00000, rt_bgez = 5'b00001, rt_bltzl = 5'b00010, rt_bgezl = 5'b00011,
		rt_tgei = 5'b01000, rt_tgeiu = 5'b01001, rt_tlti = 5'b01010, rt_tltiu = 5'b01011,
		rt_teqi = 5'b01100, rt_tnei = 5'b01110, rt_bltzal = 5'b10000, rt_bgezal = 5'b10001,
		rt_bltzall = 5'b10010, rt_bgezall = 5'b10011;

	// CACHE op in rt
	localparam logic [4:0]
		ca_i_index_inv = 5'b00000, ca_d_index_wb_inv = 5'b00001,
		ca_i_index_st_tag = 5'b01000, ca_d_index_st_tag = 5'b01001,
		ca_i_hit_inv = 5'b10000, ca_d_hit_inv = 5'b10001, ca_d_hit_wb_inv = 5'b10101;

	// COP0 rs field
	localparam logic [4:0] rs_mfc0 = 5'b00000, rs_mtc0 = 5'b00100;

	localparam logic [1:0] reg_dst_rd = 2'b00, reg_dst_rt = 2'b01, reg_dst_ra = 2'b10;

	typedef struct packed {
		logic [5:0] op;
		logic [4:0] rs;
		logic [4:0] rt;
		logic [4:0] rd;
		logic [4:0] shamt;
		logic [5:0] funct;
	} r_fmt_t;

	typedef struct packed {
		logic [5:0]  op;
		logic [4:0]  rs;
		logic [4:0]  rt;
		logic [15:0] imm;
	} i_fmt_t;

	typedef union packed {
		r_fmt_t r;
		i_fmt_t i;
	} instr_t;

	typedef struct packed {
		logic        reg_write;
		logic [1:0]  reg_dst;     // 00 rd, 01 rt, 10 $ra
		logic        alu_imm;
		logic        sign_ext;
		logic        mem_read;
		logic        mem_write;
		logic        mem_to_reg;
		logic        is_div;
		logic        is_mult;
		logic        hilo_wen;
		logic        hilo_to_reg;
		logic [1:0]  mfhi_lo;     // {mfhi, mflo}
		logic        ri;
		logic        brk;
		logic        syscall;
		logic        eret;
		logic        cp0_wen;
		logic        cp0_to_reg;
		logic [3:0]  tlb_type;    // {tlbwr, tlbwi, tlbr, tlbp}
		logic        movz;
		logic        movn;
		logic [6:0]  cache_op;
		logic [13:0] ls_type;
	} dec_ctrl_t;

	typedef struct packed {
		dec_ctrl_t   ctrl;
		logic [4:0]  rs;
		logic [4:0]  rt;
		logic [4:0]  shamt;
		logic [31:0] rs_val;
		logic [31:0] rt_val;
		logic [31:0] imm_ext;
		logic [4:0]  dest;
	} id_ex_t;

endpackage

// ==== hw/main_decoder.sv ====
module main_decoder import mips_pkg::*; (
	input  instr_t    instr,
	output dec_ctrl_t ctrl
);
	logic [5:0] op;
	logic [5:0] funct;
	logic [4:0] rs;
	logic [4:0] rt;
	logic [3:0] rf_ctrl;   // {reg_write, reg_dst, alu_imm}
	logic [2:0] mem_ctrl;  // {mem_to_reg, mem_read, mem_write}
	logic       ri;
	logic       r_type, special2, cop0, cop0_fn, cache;
	logic       madd_any, mul;
	logic       cop0_known;

	assign op    = instr.r.op;
	assign rs    = instr.r.rs;
	assign rt    = instr.i.rt;
	assign funct = instr.r.funct;

	assign r_type   = (op == op_r_type);
	assign special2 = (op == op_special2);
	assign cop0     = (op == op_cop0);
	assign cop0_fn  = cop0 && rs[4];  // CO bit
	assign cache    = (op == op_cache);

	assign mul      = special2 && (funct == s2_mul);
	assign madd_any = special2 && (funct == s2_madd || funct == s2_maddu ||
		funct == s2_msub || funct == s2_msubu);

	assign cop0_known = cop0_fn && (funct == c0_eret || funct == c0_tlbr ||
		funct == c0_tlbp || funct == c0_tlbwi || funct == c0_tlbwr || funct == c0_wait);

	always_comb begin
		ri       = 1'b0;
		rf_ctrl  = 4'b0_00_0;
		mem_ctrl = 3'b0_0_0;
		case (op)
			op_r_type: begin
				case (funct)
					fn_add, fn_addu, fn_sub, fn_subu, fn_slt, fn_sltu,
					fn_and, fn_or, fn_xor, fn_nor,
					fn_sll, fn_srl, fn_sra, fn_sllv, fn_srlv, fn_srav,
					fn_mfhi, fn_mflo, fn_movz, fn_movn:
						rf_ctrl = 4'b1_00_0;
					fn_jr, fn_mult, fn_multu, fn_div, fn_divu, fn_mthi, fn_mtlo,
					fn_syscall, fn_break, fn_sync,
					fn_teq, fn_tne, fn_tge, fn_tgeu, fn_tlt, fn_tltu:
						rf_ctrl = 4'b0_00_0;
					fn_jalr: rf_ctrl = 4'b1_10_0;  // link always to $ra
					default: begin
						ri      = 1'b1;
						rf_ctrl = 4'b1_00_0;
					end
				endcase
			end
			op_addi, op_addiu, op_slti, op_sltiu, op_andi, op_ori, op_xori, op_lui:
				rf_ctrl = 4'b1_01_1;
			op_beq, op_bne, op_blez, op_bgtz, op_beql, op_bnel, op_blezl, op_bgtzl,
			op_pref, op_j:
				rf_ctrl = 4'b0_00_0;
			op_jal: rf_ctrl = 4'b1_10_0;
			op_cache: begin
				if (rt == ca_i_index_st_tag || rt == ca_d_index_st_tag ||
					rt == ca_i_index_inv || rt == ca_d_index_wb_inv)
					rf_ctrl = 4'b0_00_1;
				else
					ri = 1'b1;
			end
			op_regimm: begin
				case (rt)
					rt_bgezal, rt_bltzal, rt_bgezall, rt_bltzall: rf_ctrl = 4'b1_10_0;
					rt_bgez, rt_bltz, rt_bgezl, rt_bltzl: rf_ctrl = 4'b0_00_0;
					rt_teqi, rt_tnei, rt_tgei, rt_tgeiu, rt_tlti, rt_tltiu:
						rf_ctrl = 4'b0_00_1;
					default: ri = 1'b1;
				endcase
			end
			op_lw, op_lb, op_lbu, op_lh, op_lhu, op_ll, op_lwl, op_lwr: begin
				rf_ctrl  = 4'b1_01_1;
				mem_ctrl = 3'b1_1_0;
			end
			op_sw, op_sb, op_sh, op_swl, op_swr: begin
				rf_ctrl  = 4'b0_00_1;
				mem_ctrl = 3'b0_0_1;
			end
			op_sc: begin  // also writes the success flag to rt
				rf_ctrl  = 4'b1_01_1;
				mem_ctrl = 3'b0_0_1;
			end
			op_cop0: begin
				case (rs)
					rs_mtc0: rf_ctrl = 4'b0_00_0;
					rs_mfc0: rf_ctrl = 4'b1_01_0;
					default: ri = !cop0_known;
				endcase
			end
			op_special2: begin
				case (funct)
					s2_mul, s2_clz, s2_clo: rf_ctrl = 4'b1_00_0;
					s2_madd, s2_maddu, s2_msub, s2_msubu: rf_ctrl = 4'b0_00_0;
					default: ri = 1'b1;
				endcase
			end
			default: ri = 1'b1;
		endcase
	end

	always_comb begin
		{ctrl.reg_write, ctrl.reg_dst, ctrl.alu_imm}    = rf_ctrl;
		{ctrl.mem_to_reg, ctrl.mem_read, ctrl.mem_write} = mem_ctrl;
		ctrl.ri          = ri;
		ctrl.sign_ext    = (op[5:2] != 4'b0011);  // andi ori xori lui zero extend
		ctrl.is_div      = r_type && (funct[5:1] == 5'b01101);
		ctrl.is_mult     = (r_type && (funct[5:1] == 5'b01100)) || mul || madd_any;
		ctrl.hilo_wen    = (r_type && (funct[5:2] == 4'b0110 ||
			(funct[5:2] == 4'b0100 && funct[0]))) || madd_any;
		ctrl.hilo_to_reg = r_type && (funct[5:2] == 4'b0100) && !funct[0];
		ctrl.mfhi_lo     = {r_type && funct == fn_mfhi, r_type && funct == fn_mflo};
		ctrl.brk         = r_type && (funct == fn_break);
		ctrl.syscall     = r_type && (funct == fn_syscall);
		ctrl.movz        = r_type && (funct == fn_movz);
		ctrl.movn        = r_type && (funct == fn_movn);
		ctrl.eret        = cop0_fn && (funct == c0_eret);
		ctrl.cp0_wen     = cop0 && (rs == rs_mtc0);
		ctrl.cp0_to_reg  = cop0 && (rs == rs_mfc0);
		ctrl.tlb_type    = {4{cop0_fn}} & {funct == c0_tlbwr, funct == c0_tlbwi,
			funct == c0_tlbr, funct == c0_tlbp};
		ctrl.cache_op    = {7{cache}} & {rt == ca_i_index_inv, rt == ca_i_index_st_tag,
			rt == ca_i_hit_inv, rt == ca_d_index_wb_inv, rt == ca_d_index_st_tag,
			rt == ca_d_hit_inv, rt == ca_d_hit_wb_inv};
		ctrl.ls_type     = {op == op_lwl, op == op_lwr, op == op_swl, op == op_swr,
			op == op_ll, op == op_sc, op == op_lw, op == op_lh, op == op_lhu,
			op == op_lb, op == op_lbu, op == op_sw, op == op_sh, op == op_sb};
	end

endmodule

// ==== hw/regfile.sv ====
module regfile (
	input  logic        clk,
	input  logic        rst,
	input  logic [4:0]  ra1,
	input  logic [4:0]  ra2,
	output logic [31:0] rd1,
	output logic [31:0] rd2,
	input  logic        we,
	input  logic [4:0]  wa,
	input  logic [31:0] wd
);
	logic [31:0] regs [32];

	always_ff @(posedge clk) begin
		if (rst) begin
			for (int i = 0; i < 32; i++)
				regs[i] <= '0;
		end else if (we && wa != 5'd0) begin
			regs[wa] <= wd;
		end
	end

	// write-first bypass and $0 hardwired
	function automatic logic [31:0] read_port(input logic [4:0] ra);
		if (ra == 5'd0)
			return '0;
		else if (we && wa == ra)
			return wd;
		else
			return regs[ra];
	endfunction

	always_comb begin
		rd1 = read_port(ra1);
		rd2 = read_port(ra2);
	end

endmodule

// ==== hw/id_ex_reg.sv ====
module id_ex_reg import mips_pkg::*; (
	input  logic        clk,
	input  logic        rst,
	input  logic        in_valid,
	output logic        in_ready,
	input  instr_t      instr,
	input  dec_ctrl_t   ctrl,
	input  logic [31:0] rs_val,
	input  logic [31:0] rt_val,
	output logic        out_valid,
	input  logic        out_ready,
	output id_ex_t      id_ex
);
	id_ex_t nxt;
	logic   accept;

	// single slot that refills in the cycle it drains
	assign in_ready = !out_valid || out_ready;
	assign accept   = in_valid && in_ready;

	always_comb begin
		nxt.ctrl   = ctrl;
		nxt.rs     = instr.r.rs;
		nxt.rt     = instr.r.rt;
		nxt.shamt  = instr.r.shamt;
		nxt.rs_val = rs_val;
		nxt.rt_val = rt_val;
		if (ctrl.sign_ext)
			nxt.imm_ext = {{16{instr.i.imm[15]}}, instr.i.imm};
		else
			nxt.imm_ext = {16'h0000, instr.i.imm};
		case (ctrl.reg_dst)
			reg_dst_rt: nxt.dest = instr.i.rt;
			reg_dst_ra: nxt.dest = 5'd31;
			default:    nxt.dest = instr.r.rd;
		endcase
	end

	always_ff @(posedge clk) begin
		if (rst)
			out_valid <= 1'b0;
		else if (accept)
			out_valid <= 1'b1;
		else if (out_ready)
			out_valid <= 1'b0;  // drained with nothing new
	end

	always_ff @(posedge clk) begin
		if (accept)
			id_ex <= nxt;
	end

endmodule

// ==== hw/id_top.sv ====
module id_top import mips_pkg::*; (
	input  logic        clk,
	input  logic        rst,
	input  logic        in_valid,
	output logic        in_ready,
	input  instr_t      instr,
	output logic        out_valid,
	input  logic        out_ready,
	output id_ex_t      id_ex,
	input  logic        wb_en,
	input  logic [4:0]  wb_addr,
	input  logic [31:0] wb_data
);
	dec_ctrl_t   ctrl;
	logic [31:0] rs_val;
	logic [31:0] rt_val;

	main_decoder u_dec (
		.instr (instr),
		.ctrl  (ctrl)
	);

	regfile u_rf (
		.clk (clk),
		.rst (rst),
		.ra1 (instr.r.rs),
		.ra2 (instr.r.rt),
		.rd1 (rs_val),
		.rd2 (rt_val),
		.we  (wb_en),
		.wa  (wb_addr),
		.wd  (wb_data)
	);

	id_ex_reg u_id_ex (
		.clk       (clk),
		.rst       (rst),
		.in_valid  (in_valid),
		.in_ready  (in_ready),
		.instr     (instr),
		.ctrl      (ctrl),
		.rs_val    (rs_val),
		.rt_val    (rt_val),
		.out_valid (out_valid),
		.out_ready (out_ready),
		.id_ex     (id_ex)
	);

endmodule

// ==== test/id_top_sva.sv ====
module id_top_sva import mips_pkg::*; (
	input logic   clk,
	input logic   rst,
	input logic   in_ready,
	input logic   out_valid,
	input logic   out_ready,
	input id_ex_t id_ex
);
	// stage comes out of reset empty
	reset_empty: assert property (@(posedge clk) rst |=> !out_valid)
		else $error("out_valid high in the cycle after reset");

	stall_hold: assert property (@(posedge clk) disable iff (rst)
		out_valid && !out_ready |=> out_valid && $stable(id_ex))
		else $error("stalled bundle changed or was dropped");

	ready_rule: assert property (@(posedge clk) disable iff (rst)
		in_ready == (!out_valid || out_ready))
		else $error("in_ready does not follow out_valid and out_ready");

endmodule

bind id_top id_top_sva u_sva (
	.clk       (clk),
	.rst       (rst),
	.in_ready  (in_ready),
	.out_valid (out_valid),
	.out_ready (out_ready),
	.id_ex     (id_ex)
);

// ==== test/tb_id_top.sv ====
module tb_id_top import mips_pkg::*; ();
	localparam int n_free = 300;
	localparam int n_bp = 300;
	localparam int n_stall = 200;
	localparam int cycle_limit = 4 * (n_free + n_bp + n_stall) + 200;
	localparam logic [5:0] c0_pick [8] = '{c0_tlbr, c0_tlbwi, c0_tlbwr, c0_tlbp, c0_eret,
		c0_wait, 6'h3f, 6'h11};

	logic        clk;
	logic        rst;
	logic        in_valid;
	logic        in_ready;
	instr_t      instr;
	logic        out_valid;
	logic        out_ready;
	id_ex_t      id_ex;
	logic        wb_en;
	logic [4:0]  wb_addr;
	logic [31:0] wb_data;

	logic [31:0] seed = 32'h4ef0_de75;
	logic [31:0] model_rf [32];
	id_ex_t      exp_q [$];
	logic        took;
	int          errors = 0;
	int          checks = 0;
	int          cycles = 0;

	id_top UUT (.*);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	always @(posedge clk) begin
		cycles++;
		if (cycles > cycle_limit) begin
			$display("timeout, run stopped after %0d cycles", cycles);
			$display("ERRORS FOUND");
			$finish;
		end
	end

	function automatic logic [31:0] xorshift();
		logic [31:0] x;
		x = seed;
		x ^= x << 13;
		x ^= x >> 17;
		x ^= x << 5;
		seed = x;
		return x;
	endfunction

	// class-biased words, the rest fully random
	function automatic logic [31:0] gen_instr();
		instr_t      w;
		logic [31:0] r;
		w = xorshift();
		r = xorshift();
		case (r[2:0])
			3'd0, 3'd1: w.r.op = op_r_type;
			3'd2: w.r.op = op_regimm;
			3'd3: begin
				w.r.op = op_cop0;
				w.r.rs = w.r.rs & 5'b10100;  // mfc0, mtc0 or CO
				if (r[3])
					w.r.funct = c0_pick[r[6:4]];
			end
			3'd4: begin
				w.r.op = op_special2;
				w.r.funct = w.r.funct & 6'b100111;
			end
			3'd5: begin
				w.i.op = op_cache;
				w.i.rt = w.i.rt & 5'b11101;
			end
			default: ;
		endcase
		return w;
	endfunction

	function automatic dec_ctrl_t model_ctrl(input logic [31:0] w);
		dec_ctrl_t  c;
		logic [5:0] op;
		logic [5:0] fn;
		logic [4:0] rs;
		logic [4:0] rt;
		logic       r, s2, co, acc;
		op = w[31:26];
		rs = w[25:21];
		rt = w[20:16];
		fn = w[5:0];
		r = (op == op_r_type);
		s2 = (op == op_special2);
		co = (op == op_cop0) && rs[4];
		acc = s2 && (fn == s2_madd || fn == s2_maddu || fn == s2_msub || fn == s2_msubu);
		c = '0;
		case (op)
			op_r_type: begin
				case (fn)
					fn_jalr: {c.reg_write, c.reg_dst} = {1'b1, reg_dst_ra};
					fn_jr, fn_mult, fn_multu, fn_div, fn_divu, fn_mthi, fn_mtlo, fn_syscall,
					fn_break, fn_sync, fn_teq, fn_tne, fn_tge, fn_tgeu, fn_tlt, fn_tltu:
						c.reg_write = 1'b0;
					fn_add, fn_addu, fn_sub, fn_subu, fn_and, fn_or, fn_xor, fn_nor, fn_slt,
					fn_sltu, fn_sll, fn_srl, fn_sra, fn_sllv, fn_srlv, fn_srav, fn_mfhi,
					fn_mflo, fn_movz, fn_movn:
						c.reg_write = 1'b1;
					default: {c.reg_write, c.ri} = 2'b11;  // unknown funct keeps the write
				endcase
			end
			op_addi, op_addiu, op_slti, op_sltiu, op_andi, op_ori, op_xori, op_lui:
				{c.reg_write, c.reg_dst, c.alu_imm} = {1'b1, reg_dst_rt, 1'b1};
			op_jal: {c.reg_write, c.reg_dst} = {1'b1, reg_dst_ra};
			op_lb, op_lh, op_lwl, op_lw, op_lbu, op_lhu, op_lwr, op_ll: begin
				{c.reg_write, c.reg_dst, c.alu_imm} = {1'b1, reg_dst_rt, 1'b1};
				{c.mem_read, c.mem_to_reg} = 2'b11;
			end
			op_sb, op_sh, op_swl, op_sw, op_swr: {c.alu_imm, c.mem_write} = 2'b11;
			op_sc: begin
				{c.reg_write, c.reg_dst, c.alu_imm} = {1'b1, reg_dst_rt, 1'b1};
				c.mem_write = 1'b1;
			end
			op_beq, op_bne, op_blez, op_bgtz, op_beql, op_bnel, op_blezl, op_bgtzl,
			op_j, op_pref: ;
			op_regimm: begin
				case (rt)
					rt_bltzal, rt_bgezal, rt_bltzall, rt_bgezall:
						{c.reg_write, c.reg_dst} = {1'b1, reg_dst_ra};
					rt_bltz, rt_bgez, rt_bltzl, rt_bgezl: ;
					rt_tgei, rt_tgeiu, rt_tlti, rt_tltiu, rt_teqi, rt_tnei: c.alu_imm = 1'b1;
					default: c.ri = 1'b1;
				endcase
			end
			op_cache: begin
				case (rt)
					ca_i_index_inv, ca_d_index_wb_inv, ca_i_index_st_tag, ca_d_index_st_tag:
						c.alu_imm = 1'b1;
					default: c.ri = 1'b1;  // hit ops are reserved here
				endcase
			end
			op_cop0: begin
				if (rs == rs_mfc0)
					{c.reg_write, c.reg_dst} = {1'b1, reg_dst_rt};
				else if (rs != rs_mtc0)
					c.ri = !(co && (fn == c0_tlbr || fn == c0_tlbwi || fn == c0_tlbwr ||
						fn == c0_tlbp || fn == c0_eret || fn == c0_wait));
			end
			op_special2: begin
				case (fn)
					s2_mul, s2_clz, s2_clo: c.reg_write = 1'b1;
					s2_madd, s2_maddu, s2_msub, s2_msubu: ;
					default: c.ri = 1'b1;
				endcase
			end
			default: c.ri = 1'b1;
		endcase
		c.sign_ext = !(op == op_andi || op == op_ori || op == op_xori || op == op_lui);
		c.is_div = r && (fn == fn_div || fn == fn_divu);
		c.is_mult = (r && (fn == fn_mult || fn == fn_multu)) || (s2 && fn == s2_mul) || acc;
		c.hilo_wen = (r && (fn == fn_mult || fn == fn_multu || fn == fn_div ||
			fn == fn_divu || fn == fn_mthi || fn == fn_mtlo)) || acc;
		c.hilo_to_reg = r && (fn == fn_mfhi || fn == fn_mflo);
		c.mfhi_lo = {r && fn == fn_mfhi, r && fn == fn_mflo};
		c.brk = r && fn == fn_break;
		c.syscall = r && fn == fn_syscall;
		c.movz = r && fn == fn_movz;
		c.movn = r && fn == fn_movn;
		c.eret = co && fn == c0_eret;
		c.cp0_wen = (op == op_cop0) && rs == rs_mtc0;
		c.cp0_to_reg = (op == op_cop0) && rs == rs_mfc0;
		c.tlb_type = {co && fn == c0_tlbwr, co && fn == c0_tlbwi, co && fn == c0_tlbr,
			co && fn == c0_tlbp};
		if (op == op_cache)
			c.cache_op = {rt == ca_i_index_inv, rt == ca_i_index_st_tag, rt == ca_i_hit_inv,
				rt == ca_d_index_wb_inv, rt == ca_d_index_st_tag, rt == ca_d_hit_inv,
				rt == ca_d_hit_wb_inv};
		c.ls_type = {op == op_lwl, op == op_lwr, op == op_swl, op == op_swr, op == op_ll,
			op == op_sc, op == op_lw, op == op_lh, op == op_lhu, op == op_lb, op == op_lbu,
			op == op_sw, op == op_sh, op == op_sb};
		return c;
	endfunction

	// write-back in the same cycle wins
	function automatic logic [31:0] model_read(input logic [4:0] a);
		if (a == 5'd0)
			return '0;
		if (wb_en && wb_addr == a)
			return wb_data;
		return model_rf[a];
	endfunction

	function automatic id_ex_t model_bundle(input logic [31:0] w);
		id_ex_t e;
		e.ctrl = model_ctrl(w);
		e.rs = w[25:21];
		e.rt = w[20:16];
		e.shamt = w[10:6];
		e.rs_val = model_read(w[25:21]);
		e.rt_val = model_read(w[20:16]);
		e.imm_ext = e.ctrl.sign_ext ? {{16{w[15]}}, w[15:0]} : {16'h0000, w[15:0]};
		case (e.ctrl.reg_dst)
			reg_dst_rt: e.dest = w[20:16];
			reg_dst_ra: e.dest = 5'd31;
			default:    e.dest = w[15:11];
		endcase
		return e;
	endfunction

	task automatic check_field(input string name, input logic [63:0] got,
		input logic [63:0] exp);
		checks++;
		assert (got === exp) else begin
			$display("FAILED %0t %s got %h expected %h", $time, name, got, exp);
			errors++;
		end
	endtask

	task automatic compare_bundle(input id_ex_t got, input id_ex_t exp);
		check_field("id_ex.ctrl", 64'(got.ctrl), 64'(exp.ctrl));
		check_field("id_ex.rs", 64'(got.rs), 64'(exp.rs));
		check_field("id_ex.rt", 64'(got.rt), 64'(exp.rt));
		check_field("id_ex.shamt", 64'(got.shamt), 64'(exp.shamt));
		check_field("id_ex.rs_val", 64'(got.rs_val), 64'(exp.rs_val));
		check_field("id_ex.rt_val", 64'(got.rt_val), 64'(exp.rt_val));
		check_field("id_ex.imm_ext", 64'(got.imm_ext), 64'(exp.imm_ext));
		check_field("id_ex.dest", 64'(got.dest), 64'(exp.dest));
	endtask

	// inputs and outputs are settled at the falling edge
	always @(negedge clk) begin
		if (rst) begin
			took = 1'b0;
			for (int i = 0; i < 32; i++)
				model_rf[i] = '0;
		end else begin
			took = in_valid && in_ready;
			assert (exp_q.size() == int'(out_valid)) else begin
				$display("stage holds %0d expected bundles while out_valid is %b at %0t",
					exp_q.size(), out_valid, $time);
				errors++;
			end
			if (out_valid && out_ready && exp_q.size() != 0)
				compare_bundle(id_ex, exp_q.pop_front());
			if (took)
				exp_q.push_back(model_bundle(instr));
			if (wb_en && wb_addr != 5'd0)
				model_rf[wb_addr] = wb_data;
		end
	end

	task automatic run_stream(input string name, input int n, input int ready_pct);
		int          sent;
		int          err0;
		logic [31:0] r;
		sent = 0;
		err0 = errors;
		while (sent < n) begin
			@(posedge clk);
			#1;
			if (in_valid && took)
				sent++;
			if (!in_valid || took) begin  // word may change only when not held
				in_valid = (sent < n) && (xorshift() % 4 != 0);
				if (in_valid)
					instr = gen_instr();
			end
			out_ready = (xorshift() % 100) < ready_pct;
			r = xorshift();
			wb_en = r[0];
			wb_addr = r[1] ? instr.r.rs : (r[2] ? instr.r.rt : r[7:3]);
			wb_data = xorshift();
		end
		while (exp_q.size() != 0) begin
			@(posedge clk);
			#1;
			out_ready = 1'b1;
			wb_en = 1'b0;
		end
		$display("%s: %0d instructions, %0d errors", name, n, errors - err0);
	endtask

	initial begin
		int err0;
		rst = 1'b1;
		in_valid = 1'b0;
		instr = '0;
		out_ready = 1'b0;
		wb_en = 1'b0;
		wb_addr = '0;
		wb_data = '0;
		repeat (4) @(posedge clk);
		#1 rst = 1'b0;
		@(negedge clk);
		err0 = errors;
		check_field("out_valid", 64'(out_valid), 64'd0);
		check_field("in_ready", 64'(in_ready), 64'd1);
		$display("reset: %0d errors", errors - err0);
		run_stream("free-flow decode", n_free, 100);
		run_stream("random back-pressure", n_bp, 50);
		run_stream("heavy back-pressure", n_stall, 30);
		$display("done: %0d checks, %0d errors", checks, errors);
		if (errors == 0)
			$display("NO ERRORS");
		else
			$display("ERRORS FOUND");
		$finish;
	end

endmodule

// ==== all.f ====
hw/mips_pkg.sv
hw/main_decoder.sv
hw/regfile.sv
hw/id_ex_reg.sv
hw/id_top.sv
test/id_top_sva.sv
test/tb_id_top.sv

// ==== Bender.yml ====
package:
  name: mips_id_stage

sources:
  - hw/mips_pkg.sv
  - hw/main_decoder.sv
  - hw/regfile.sv
  - hw/id_ex_reg.sv
  - hw/id_top.sv
  - target: test
    files:
      - test/id_top_sva.sv
      - test/tb_id_top.sv
